// ==== dcache_pkg.sv ====
package dcache_pkg;

    // Address geometry, one 32-bit word per line
    localparam int TAG_W    = 9;
    localparam int IDX_W    = 8;
    localparam int ADDR_W   = TAG_W + IDX_W;
    localparam int NUM_SETS = 1 << IDX_W;

    // Processor request, zero mask reads and non-zero mask writes
    typedef struct packed {
        logic              sel;
        logic [ADDR_W-1:0] addr;
        logic [31:0]       wdata;
        logic [3:0]        mask;
    } cpu_req_t;

    // Memory request, full strobe for write-back and zero for fetch
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [31:0]       wdata;
        logic [3:0]        wstrb;
    } mem_req_t;

    // One stored line
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [31:0]      data;
    } way_entry_t;

    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,
        ST_FETCH     = 2'd1,
        ST_WRITEBACK = 2'd2
    } ctrl_state_e;

endpackage

// ==== dcache_way_ram.sv ====
`timescale 1ns/1ps

module dcache_way_ram (
    input  logic                         clk_i,
    input  logic                         we_i,
    input  logic [3:0]                   wmask_i,
    input  logic [dcache_pkg::IDX_W-1:0] idx_i,
    input  dcache_pkg::way_entry_t       wentry_i,
    output dcache_pkg::way_entry_t       rentry_o
);
    import dcache_pkg::*;

    way_entry_t entries [NUM_SETS];

    // Tag always written, data only on enabled byte lanes
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            entries[idx_i].tag <= wentry_i.tag;
            for (int b = 0; b < 4; b++) begin
                if (wmask_i[b]) begin
                    entries[idx_i].data[8*b +: 8] <= wentry_i.data[8*b +: 8];
                end
            end
        end
    end

    // Asynchronous read for same-cycle hit
    assign rentry_o = entries[idx_i];

endmodule

// ==== dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  dcache_pkg::cpu_req_t         cpu_req_i,
    output logic [31:0]                  cpu_rdata_o,
    output logic                         cpu_stall_o,
    output dcache_pkg::mem_req_t         mem_req_o,
    input  logic [31:0]                  mem_rdata_i,
    input  logic                         mem_ready_i,
    input  dcache_pkg::way_entry_t       way_rd0_i,
    input  dcache_pkg::way_entry_t       way_rd1_i,
    output logic [1:0]                   way_we_o,
    output logic [3:0]                   way_wmask_o,
    output dcache_pkg::way_entry_t       way_wentry_o,
    output logic [dcache_pkg::IDX_W-1:0] idx_o
);
    import dcache_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    // Per-way line status, one bit per set
    logic [1:0][NUM_SETS-1:0] valid_q;
    logic [1:0][NUM_SETS-1:0] dirty_q;
    logic [NUM_SETS-1:0]      lru_q;

    logic [TAG_W-1:0] req_tag;
    logic [IDX_W-1:0] req_idx;
    logic             is_write;
    logic             full_write;
    logic             hit0;
    logic             hit1;
    logic             hit;
    logic             victim;
    logic             victim_dirty;
    way_entry_t       victim_entry;
    logic [31:0]      merged;

    // Update controls from the FSM
    logic             use_way;
    logic             way_wr;
    logic             touch;
    logic             wr_dirty;
    logic [3:0]       wr_mask;
    logic [31:0]      wr_data;
    logic             stall;

    assign req_tag    = cpu_req_i.addr[ADDR_W-1:IDX_W];
    assign req_idx    = cpu_req_i.addr[IDX_W-1:0];
    assign is_write   = |cpu_req_i.mask;
    assign full_write = &cpu_req_i.mask;

    assign hit0 = valid_q[0][req_idx] && (way_rd0_i.tag == req_tag);
    assign hit1 = valid_q[1][req_idx] && (way_rd1_i.tag == req_tag);
    assign hit  = hit0 || hit1;

    // LRU bit names the way to replace
    assign victim       = lru_q[req_idx];
    assign victim_entry = victim ? way_rd1_i : way_rd0_i;
    assign victim_dirty = valid_q[victim][req_idx] && dirty_q[victim][req_idx];

    // Fetched word with the written bytes laid over it
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = cpu_req_i.mask[b] ? cpu_req_i.wdata[8*b +: 8]
                                                 : mem_rdata_i[8*b +: 8];
        end
    end

    always_comb begin
        state_d  = state_q;
        use_way  = victim;
        way_wr   = 1'b0;
        touch    = 1'b0;
        wr_dirty = 1'b0;
        wr_mask  = 4'hf;
        wr_data  = cpu_req_i.wdata;
        stall    = 1'b1;

        case (state_q)
            ST_IDLE: begin
                stall = 1'b0;
                if (cpu_req_i.sel) begin
                    if (hit) begin
                        use_way  = hit1;
                        touch    = 1'b1;
                        way_wr   = is_write;
                        wr_dirty = 1'b1;
                        wr_mask  = cpu_req_i.mask;
                    end else if (victim_dirty) begin
                        stall   = 1'b1;
                        state_d = ST_WRITEBACK;
                    end else if (full_write) begin
                        // Whole word replaces the line, no fetch
                        touch    = 1'b1;
                        way_wr   = 1'b1;
                        wr_dirty = 1'b1;
                    end else begin
                        stall   = 1'b1;
                        state_d = ST_FETCH;
                    end
                end
            end

            ST_FETCH: begin
                if (mem_ready_i) begin
                    state_d  = ST_IDLE;
                    touch    = 1'b1;
                    way_wr   = 1'b1;
                    wr_dirty = is_write;
                    wr_data  = merged;
                end
            end

            ST_WRITEBACK: begin
                if (mem_ready_i) begin
                    if (full_write) begin
                        state_d  = ST_IDLE;
                        touch    = 1'b1;
                        way_wr   = 1'b1;
                        wr_dirty = 1'b1;
                    end else begin
                        state_d = ST_FETCH;
                    end
                end
            end

            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            state_q <= state_d;
            // Only the chosen way's status changes
            if (way_wr) begin
                valid_q[use_way][req_idx] <= 1'b1;
                dirty_q[use_way][req_idx] <= wr_dirty;
            end
            if (touch) begin
                lru_q[req_idx] <= ~use_way;
            end
        end
    end

    assign cpu_rdata_o = hit1 ? way_rd1_i.data : way_rd0_i.data;
    assign cpu_stall_o = stall;

    assign way_we_o[0]      = way_wr && !use_way;
    assign way_we_o[1]      = way_wr && use_way;
    assign way_wmask_o      = wr_mask;
    assign way_wentry_o.tag = req_tag;
    assign way_wentry_o.data = wr_data;
    assign idx_o            = req_idx;

    // Request fields follow the held processor request and victim entry
    always_comb begin
        mem_req_o.valid = (state_q != ST_IDLE);
        mem_req_o.addr  = cpu_req_i.addr;
        mem_req_o.wdata = '0;
        mem_req_o.wstrb = 4'h0;
        if (state_q == ST_WRITEBACK) begin
            mem_req_o.addr  = {victim_entry.tag, req_idx};
            mem_req_o.wdata = victim_entry.data;
            mem_req_o.wstrb = 4'hf;
        end
    end

endmodule

// ==== dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  dcache_pkg::cpu_req_t cpu_req_i,
    output logic [31:0]          cpu_rdata_o,
    output logic                 cpu_stall_o,
    output dcache_pkg::mem_req_t mem_req_o,
    input  logic [31:0]          mem_rdata_i,
    input  logic                 mem_ready_i
);
    import dcache_pkg::*;

    way_entry_t       way_rd0;
    way_entry_t       way_rd1;
    logic [1:0]       way_we;
    logic [3:0]       way_wmask;
    way_entry_t       way_wentry;
    logic [IDX_W-1:0] idx;

    dcache_ctrl ctrl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cpu_req_i    (cpu_req_i),
        .cpu_rdata_o  (cpu_rdata_o),
        .cpu_stall_o  (cpu_stall_o),
        .mem_req_o    (mem_req_o),
        .mem_rdata_i  (mem_rdata_i),
        .mem_ready_i  (mem_ready_i),
        .way_rd0_i    (way_rd0),
        .way_rd1_i    (way_rd1),
        .way_we_o     (way_we),
        .way_wmask_o  (way_wmask),
        .way_wentry_o (way_wentry),
        .idx_o        (idx)
    );

    dcache_way_ram way0 (
        .clk_i    (clk_i),
        .we_i     (way_we[0]),
        .wmask_i  (way_wmask),
        .idx_i    (idx),
        .wentry_i (way_wentry),
        .rentry_o (way_rd0)
    );

    dcache_way_ram way1 (
        .clk_i    (clk_i),
        .we_i     (way_we[1]),
        .wmask_i  (way_wmask),
        .idx_i    (idx),
        .wentry_i (way_wentry),
        .rentry_o (way_rd1)
    );

endmodule

// ==== dcache_mem_model.sv ====
`timescale 1ns/1ps

module dcache_mem_model #(
    parameter int MAX_DELAY = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  dcache_pkg::mem_req_t mem_req_i,
    output logic [31:0]          mem_rdata_o,
    output logic                 mem_ready_o
);
    import dcache_pkg::*;

    logic [31:0] mem [1 << ADDR_W];
    int unsigned wait_q;

    // Spreads neighbouring addresses apart, every address bit counts
    function automatic logic [31:0] initial_word(input logic [ADDR_W-1:0] addr);
        return (32'(addr) * 32'h9e3779b1) ^ {15'h2b6d, addr};
    endfunction

    initial begin
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            mem[a] = initial_word(ADDR_W'(a));
        end
    end

    assign mem_ready_o = mem_req_i.valid && (wait_q == 0);
    assign mem_rdata_o = mem[mem_req_i.addr];

    // Each transfer waits a fresh random number of cycles
    always @(posedge clk_i) begin
        if (rst_i) begin
            wait_q <= 0;
        end else if (mem_req_i.valid) begin
            if (mem_ready_o) begin
                wait_q <= $urandom_range(MAX_DELAY, 0);
                for (int b = 0; b < 4; b++) begin
                    if (mem_req_i.wstrb[b]) begin
                        mem[mem_req_i.addr][8*b +: 8] = mem_req_i.wdata[8*b +: 8];
                    end
                end
            end else begin
                wait_q <= wait_q - 1;
            end
        end
    end

endmodule

// ==== dcache_props.sv ====
`timescale 1ns/1ps

module dcache_props (
    input logic                 clk_i,
    input logic                 rst_i,
    input dcache_pkg::cpu_req_t cpu_req_i,
    input logic                 cpu_stall_o,
    input dcache_pkg::mem_req_t mem_req_o,
    input logic                 mem_ready_i
);
    import dcache_pkg::*;

    // Number of failed assertions
    int fail_count = 0;

    reset_idle: assert property (@(posedge clk_i)
        rst_i |=> (!cpu_stall_o && !mem_req_o.valid))
        else begin
            $error("Cache not idle in the cycle after reset");
            fail_count = fail_count + 1;
        end

    // Held request must not change until memory accepts it
    mem_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        (mem_req_o.valid && !mem_ready_i) |=> $stable(mem_req_o))
        else begin
            $error("Memory request changed while waiting for ready");
            fail_count = fail_count + 1;
        end

    // Back-to-back read of the same word
    repeat_read_hit: assert property (@(posedge clk_i) disable iff (rst_i)
        (cpu_req_i.sel && cpu_req_i.mask == 4'h0 && $stable(cpu_req_i.addr)
            && $past(cpu_req_i.sel && !cpu_stall_o && cpu_req_i.mask == 4'h0))
        |-> (!cpu_stall_o && !mem_req_o.valid))
        else begin
            $error("Repeated read did not hit in its first cycle");
            fail_count = fail_count + 1;
        end

endmodule

bind dcache_top dcache_props props (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cpu_req_i   (cpu_req_i),
    .cpu_stall_o (cpu_stall_o),
    .mem_req_o   (mem_req_o),
    .mem_ready_i (mem_ready_i)
);

// ==== dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int NUM_REQ        = 600;
    localparam int MEM_MAX_DELAY  = 4;
    // Write-back plus fetch at full delay, the final hit and idle gaps
    localparam int TIMEOUT_CYCLES = 16 + NUM_REQ * (2 * (MEM_MAX_DELAY + 1) + 8) + 200;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    cpu_req_t    cpu_req = '0;
    logic [31:0] cpu_rdata;
    logic        cpu_stall;
    mem_req_t    mem_req;
    logic [31:0] mem_rdata;
    logic        mem_ready;

    logic first_cycle = 1'b0;
    logic repeat_read = 1'b0;

    logic [31:0]       shadow [1 << ADDR_W];
    logic [31:0]       exp_rdata;
    logic [31:0]       exp_wb;
    logic [TAG_W-1:0]  tag_pool [4];
    logic [IDX_W-1:0]  idx_pool [3];
    logic              last_read;
    logic [ADDR_W-1:0] last_addr;

    int read_errs = 0;
    int hit_errs  = 0;
    int wb_errs   = 0;

    dcache_top uut (
        .clk_i       (clk),
        .rst_i       (rst),
        .cpu_req_i   (cpu_req),
        .cpu_rdata_o (cpu_rdata),
        .cpu_stall_o (cpu_stall),
        .mem_req_o   (mem_req),
        .mem_rdata_i (mem_rdata),
        .mem_ready_i (mem_ready)
    );

    dcache_mem_model #(.MAX_DELAY(MEM_MAX_DELAY)) mem (
        .clk_i       (clk),
        .rst_i       (rst),
        .mem_req_i   (mem_req),
        .mem_rdata_o (mem_rdata),
        .mem_ready_o (mem_ready)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    assign exp_rdata = shadow[cpu_req.addr];
    assign exp_wb    = shadow[mem_req.addr];

    read_data_check: assert property (@(posedge clk) disable iff (rst)
        (cpu_req.sel && !cpu_stall && cpu_req.mask == 4'h0) |-> (cpu_rdata == exp_rdata))
        else begin
            read_errs = read_errs + 1;
            $display("MISMATCH cpu_rdata_o addr=%h got=%h exp=%h", $sampled(cpu_req.addr),
                $sampled(cpu_rdata), $sampled(exp_rdata));
        end

    repeat_hit_check: assert property (@(posedge clk) disable iff (rst)
        (cpu_req.sel && first_cycle && repeat_read) |-> (!cpu_stall && !mem_req.valid))
        else begin
            hit_errs = hit_errs + 1;
            $display("Repeated read of address %h did not hit at once", $sampled(cpu_req.addr));
        end

    wb_strobe_check: assert property (@(posedge clk) disable iff (rst)
        (mem_req.valid && mem_ready && mem_req.wstrb != 4'h0) |-> (mem_req.wstrb == 4'hf))
        else begin
            wb_errs = wb_errs + 1;
            $display("MISMATCH mem_req_o.wstrb got=%h exp=%h", $sampled(mem_req.wstrb), 4'hf);
        end

    wb_data_check: assert property (@(posedge clk) disable iff (rst)
        (mem_req.valid && mem_ready && mem_req.wstrb != 4'h0) |-> (mem_req.wdata == exp_wb))
        else begin
            wb_errs = wb_errs + 1;
            $display("MISMATCH mem_req_o.wdata addr=%h got=%h exp=%h", $sampled(mem_req.addr),
                $sampled(mem_req.wdata), $sampled(exp_wb));
        end

    function automatic logic [31:0] initial_word(input logic [ADDR_W-1:0] addr);
        return (32'(addr) * 32'h9e3779b1) ^ {15'h2b6d, addr};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  mask);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Presents a request and returns once it is about to complete
    task automatic run_request(input cpu_req_t req, input logic is_repeat);
        @(posedge clk);
        cpu_req     <= req;
        first_cycle <= 1'b1;
        repeat_read <= is_repeat;
        @(negedge clk);
        while (cpu_stall) begin
            @(posedge clk);
            first_cycle <= 1'b0;
            @(negedge clk);
        end
        if (req.mask != 4'h0) begin
            shadow[req.addr] = merge_bytes(shadow[req.addr], req.wdata, req.mask);
        end
    endtask

    task automatic idle_cycles(input int n);
        @(posedge clk);
        cpu_req     <= '0;
        first_cycle <= 1'b0;
        repeat (n - 1) @(posedge clk);
    endtask

    initial begin
        cpu_req_t req;
        logic     rpt;
        int       pick;
        void'($urandom(26334));
        tag_pool = '{9'h000, 9'h0b5, 9'h15a, 9'h1ff};
        idx_pool = '{8'h00, 8'h3c, 8'hff};
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            shadow[a] = initial_word(ADDR_W'(a));
        end
        last_read = 1'b0;
        last_addr = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        idle_cycles(2);
        for (int n = 0; n < NUM_REQ; n++) begin
            rpt = last_read && ($urandom_range(3, 0) == 0);
            req.sel   = 1'b1;
            req.wdata = $urandom();
            if (rpt) begin
                req.addr = last_addr;
                req.mask = 4'h0;
            end else begin
                // Few tags on few sets, so sets overflow and dirty lines get evicted
                req.addr = {tag_pool[2'($urandom_range(3, 0))],
                            idx_pool[2'($urandom_range(2, 0))]};
                pick = $urandom_range(9, 0);
                if (pick < 4) begin
                    req.mask = 4'h0;
                end else if (pick < 6) begin
                    req.mask = 4'hf;
                end else begin
                    req.mask = 4'($urandom_range(14, 1));
                end
            end
            run_request(req, rpt);
            last_read = (req.mask == 4'h0);
            last_addr = req.addr;
            if ($urandom_range(7, 0) == 0) begin
                idle_cycles(1 + $urandom_range(1, 0));
            end
        end
        idle_cycles(4);
        $display("Errors: read data %0d, read hit %0d, write-back %0d, properties %0d",
            read_errs, hit_errs, wb_errs, uut.props.fail_count);
        if (read_errs + hit_errs + wb_errs + uut.props.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * 20);
        $display("Timeout after %0d cycles, a request never completed", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== dcache.f ====
dcache_pkg.sv
dcache_way_ram.sv
dcache_ctrl.sv
dcache_top.sv
dcache_mem_model.sv
dcache_props.sv
dcache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the data cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module dcache_tb \
    -f dcache.f \
    -o dcache_sim

./obj_dir/dcache_sim | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
